/* verilog/addr_cmd_consts.svh */
`ifndef ADDR_CMD_CONSTS_SVH
`define ADDR_CMD_CONSTS_SVH

// ****************************************
// memory side field widths
// ****************************************

`define ADDR_W              15
`define BANK_W              3
`define CS_W                1
`define CKE_W               1
`define ODT_W               1
// each of ras_n, cas_n, we_n and reset_n
`define CTRL_W              1
`define CK_W                1

// ****************************************
// reset levels of the serialized words
// ****************************************

// single bits, replicated to the field width where used
`define CS_N_RST            1'b1
`define CMD_N_RST           1'b1
`define CKE_RST             1'b0
`define MEM_RESET_RST       1'b0

// flops between the raw reset release and the phase generator
`define RESET_SYNC_STAGES   2

`endif

/* verilog/addr_cmd_pkg.sv */
`default_nettype none

`include "addr_cmd_consts.svh"

package addr_cmd_pkg;

    // ****************************************
    // full-rate fields, one memory word each
    // ****************************************

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`BANK_W-1:0] bank_t;
    typedef logic [`CS_W-1:0]   cs_n_t;
    typedef logic [`CKE_W-1:0]  cke_t;
    typedef logic [`ODT_W-1:0]  odt_t;
    typedef logic [`CTRL_W-1:0] ctrl_t;
    typedef logic [`CK_W-1:0]   ck_en_t;

    // ****************************************
    // half-rate pairs from the AFI side
    // ****************************************

    // low half sits in the lower bits and goes out first
    typedef logic [2*`ADDR_W-1:0] addr_pair_t;
    typedef logic [2*`BANK_W-1:0] bank_pair_t;
    typedef logic [2*`CS_W-1:0]   cs_n_pair_t;
    typedef logic [2*`CKE_W-1:0]  cke_pair_t;
    typedef logic [2*`ODT_W-1:0]  odt_pair_t;
    typedef logic [2*`CTRL_W-1:0] ctrl_pair_t;

    // serializer phase, LO is the capture cycle
    typedef enum logic
    {
        PHASE_LO = 1'b0,
        PHASE_HI = 1'b1
    } phase_t;

endpackage

`default_nettype wire

/* verilog/hr_phase_gen.sv */
`default_nettype none

`include "addr_cmd_consts.svh"

module hr_phase_gen
(
    input  logic                 pll_mem_clk,
    input  logic                 arst_n,
    output addr_cmd_pkg::phase_t phase
);

    import addr_cmd_pkg::*;

    // shift register that carries the reset release into the clock domain
    logic [`RESET_SYNC_STAGES-1:0] sync_q;
    // synchronized release delayed by one more cycle for edge detection
    logic                          sync_d_q;
    logic                          start;

    always_ff @(posedge pll_mem_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_q   <= '0;
            sync_d_q <= 1'b0;
        end
        else
        begin
            sync_q   <= {sync_q[`RESET_SYNC_STAGES-2:0], 1'b1};
            sync_d_q <= sync_q[`RESET_SYNC_STAGES-1];
        end
    end

    // one-cycle pulse on the first cycle the synchronized reset is released
    assign start = sync_q[`RESET_SYNC_STAGES-1] & ~sync_d_q;

    // phase sits in HI until the start pulse, so no pair is captured
    // while the synchronizer is still filling
    always_ff @(posedge pll_mem_clk or negedge arst_n)
    begin
        if (!arst_n)
            phase <= PHASE_HI;
        else if (start)
            phase <= PHASE_LO;
        else if (sync_d_q)
            phase <= (phase == PHASE_LO) ? PHASE_HI : PHASE_LO;
    end

endmodule

`default_nettype wire

/* verilog/hr_to_fr_serializer.sv */
`default_nettype none

module hr_to_fr_serializer
#(
    parameter int               WIDTH       = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
)
(
    input  logic                 pll_mem_clk,
    input  logic                 arst_n,
    input  addr_cmd_pkg::phase_t phase,
    input  logic [2*WIDTH-1:0]   pair,
    output logic [WIDTH-1:0]     word
);

    import addr_cmd_pkg::*;

    // high half parked here for the cycle after capture
    logic [WIDTH-1:0] hold_q;

    // ****************************************
    // two-word serializer
    // ****************************************

    // the hold register is read on every HI phase, including the ones
    // before the first capture, so it must come out of reset at the
    // idle level of the pin
    always_ff @(posedge pll_mem_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            word   <= RESET_VALUE;
            hold_q <= RESET_VALUE;
        end
        else if (phase == PHASE_LO)
        begin
            // capture edge: low half goes straight out
            word   <= pair[WIDTH-1:0];
            hold_q <= pair[2*WIDTH-1:WIDTH];
        end
        else
        begin
            word <= hold_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_out_stage.sv */
`default_nettype none

module cmd_out_stage
(
    input  logic                 pll_mem_clk,
    input  logic                 arst_n,

    input  addr_cmd_pkg::ck_en_t enable_mem_clk,

    // serialized words
    input  addr_cmd_pkg::addr_t  address,
    input  addr_cmd_pkg::bank_t  bank,
    input  addr_cmd_pkg::cs_n_t  cs_n,
    input  addr_cmd_pkg::odt_t   odt,
    input  addr_cmd_pkg::ctrl_t  ras_n,
    input  addr_cmd_pkg::ctrl_t  cas_n,
    input  addr_cmd_pkg::ctrl_t  we_n,

    // memory pins that float while every clock is off
    output addr_cmd_pkg::addr_t  mem_address,
    output addr_cmd_pkg::bank_t  mem_bank,
    output addr_cmd_pkg::cs_n_t  mem_cs_n,
    output addr_cmd_pkg::odt_t   mem_odt,
    output addr_cmd_pkg::ctrl_t  mem_ras_n,
    output addr_cmd_pkg::ctrl_t  mem_cas_n,
    output addr_cmd_pkg::ctrl_t  mem_we_n
);

    // set while at least one memory clock pair is running
    logic oe_q;

    // ****************************************
    // output enable register
    // ****************************************

    always_ff @(posedge pll_mem_clk or negedge arst_n)
    begin
        if (!arst_n)
            oe_q <= 1'b0;
        else
            oe_q <= |enable_mem_clk;
    end

    // ****************************************
    // tri-state drivers
    // ****************************************

    // the whole command bus is released together, so the memory never
    // sees a partly driven command
    assign mem_address = oe_q ? address : 'z;
    assign mem_bank    = oe_q ? bank    : 'z;
    assign mem_cs_n    = oe_q ? cs_n    : 'z;
    assign mem_odt     = oe_q ? odt     : 'z;
    assign mem_ras_n   = oe_q ? ras_n   : 'z;
    assign mem_cas_n   = oe_q ? cas_n   : 'z;
    assign mem_we_n    = oe_q ? we_n    : 'z;

endmodule

`default_nettype wire

/* verilog/mem_ck_gen.sv */
`default_nettype none

`include "addr_cmd_consts.svh"

module mem_ck_gen
(
    input  logic                 pll_mem_clk,
    input  logic                 arst_n,
    input  addr_cmd_pkg::ck_en_t enable_mem_clk,
    output addr_cmd_pkg::ck_en_t mem_ck,
    output addr_cmd_pkg::ck_en_t mem_ck_n
);

    // enables retimed to the falling edge of the source clock
    logic [`CK_W-1:0] en_q;
    logic [`CK_W-1:0] ck_gated;

    // ****************************************
    // per-pair clock gate
    // ****************************************

    for (genvar i = 0; i < `CK_W; i++)
    begin : g_ck

        // the enable only moves while pll_mem_clk is low, so the AND below
        // cannot chop a high pulse
        always_ff @(negedge pll_mem_clk or negedge arst_n)
        begin
            if (!arst_n)
                en_q[i] <= 1'b0;
            else
                en_q[i] <= enable_mem_clk[i];
        end

        assign ck_gated[i] = pll_mem_clk & en_q[i];

        // parked pair is ck low, ck_n high
        assign mem_ck[i]   = ck_gated[i];
        assign mem_ck_n[i] = ~ck_gated[i];

    end

endmodule

`default_nettype wire

/* verilog/addr_cmd_pads.sv */
`default_nettype none

`include "addr_cmd_consts.svh"

module addr_cmd_pads
(
    input  logic                     pll_mem_clk,
    input  logic                     arst_n,
    input  addr_cmd_pkg::ck_en_t     enable_mem_clk,

    // half-rate AFI fields
    input  addr_cmd_pkg::addr_pair_t afi_address,
    input  addr_cmd_pkg::bank_pair_t afi_bank,
    input  addr_cmd_pkg::cs_n_pair_t afi_cs_n,
    input  addr_cmd_pkg::cke_pair_t  afi_cke,
    input  addr_cmd_pkg::odt_pair_t  afi_odt,
    input  addr_cmd_pkg::ctrl_pair_t afi_ras_n,
    input  addr_cmd_pkg::ctrl_pair_t afi_cas_n,
    input  addr_cmd_pkg::ctrl_pair_t afi_we_n,
    input  addr_cmd_pkg::ctrl_pair_t afi_reset_n,

    // memory pins
    output addr_cmd_pkg::addr_t      mem_address,
    output addr_cmd_pkg::bank_t      mem_bank,
    output addr_cmd_pkg::cs_n_t      mem_cs_n,
    output addr_cmd_pkg::cke_t       mem_cke,
    output addr_cmd_pkg::odt_t       mem_odt,
    output addr_cmd_pkg::ctrl_t      mem_ras_n,
    output addr_cmd_pkg::ctrl_t      mem_cas_n,
    output addr_cmd_pkg::ctrl_t      mem_we_n,
    output addr_cmd_pkg::ctrl_t      mem_reset_n,
    output addr_cmd_pkg::ck_en_t     mem_ck,
    output addr_cmd_pkg::ck_en_t     mem_ck_n
);

    import addr_cmd_pkg::*;

    phase_t phase;

    // full-rate words ahead of the output enable
    addr_t  ser_address;
    bank_t  ser_bank;
    cs_n_t  ser_cs_n;
    odt_t   ser_odt;
    ctrl_t  ser_ras_n;
    ctrl_t  ser_cas_n;
    ctrl_t  ser_we_n;

    // ****************************************
    // pair alignment
    // ****************************************

    hr_phase_gen u_phase_gen
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase)
    );

    // ****************************************
    // half to full rate serializers
    // ****************************************

    hr_to_fr_serializer #(.WIDTH(`ADDR_W), .RESET_VALUE('0)) u_ser_address
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_address),
        .word        (ser_address)
    );

    hr_to_fr_serializer #(.WIDTH(`BANK_W), .RESET_VALUE('0)) u_ser_bank
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_bank),
        .word        (ser_bank)
    );

    hr_to_fr_serializer #(.WIDTH(`CS_W), .RESET_VALUE({`CS_W{`CS_N_RST}})) u_ser_cs_n
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_cs_n),
        .word        (ser_cs_n)
    );

    // cke and reset_n bypass the output enable and drive the pins directly
    hr_to_fr_serializer #(.WIDTH(`CKE_W), .RESET_VALUE({`CKE_W{`CKE_RST}})) u_ser_cke
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_cke),
        .word        (mem_cke)
    );

    hr_to_fr_serializer #(.WIDTH(`ODT_W), .RESET_VALUE('0)) u_ser_odt
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_odt),
        .word        (ser_odt)
    );

    hr_to_fr_serializer #(.WIDTH(`CTRL_W), .RESET_VALUE({`CTRL_W{`CMD_N_RST}})) u_ser_ras_n
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_ras_n),
        .word        (ser_ras_n)
    );

    hr_to_fr_serializer #(.WIDTH(`CTRL_W), .RESET_VALUE({`CTRL_W{`CMD_N_RST}})) u_ser_cas_n
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_cas_n),
        .word        (ser_cas_n)
    );

    hr_to_fr_serializer #(.WIDTH(`CTRL_W), .RESET_VALUE({`CTRL_W{`CMD_N_RST}})) u_ser_we_n
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_we_n),
        .word        (ser_we_n)
    );

    hr_to_fr_serializer #(.WIDTH(`CTRL_W), .RESET_VALUE({`CTRL_W{`MEM_RESET_RST}}))
        u_ser_reset_n
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .pair        (afi_reset_n),
        .word        (mem_reset_n)
    );

    // ****************************************
    // output enable and memory clock
    // ****************************************

    cmd_out_stage u_out_stage
    (
        .pll_mem_clk    (pll_mem_clk),
        .arst_n         (arst_n),
        .enable_mem_clk (enable_mem_clk),
        .address        (ser_address),
        .bank           (ser_bank),
        .cs_n           (ser_cs_n),
        .odt            (ser_odt),
        .ras_n          (ser_ras_n),
        .cas_n          (ser_cas_n),
        .we_n           (ser_we_n),
        .mem_address    (mem_address),
        .mem_bank       (mem_bank),
        .mem_cs_n       (mem_cs_n),
        .mem_odt        (mem_odt),
        .mem_ras_n      (mem_ras_n),
        .mem_cas_n      (mem_cas_n),
        .mem_we_n       (mem_we_n)
    );

    mem_ck_gen u_ck_gen
    (
        .pll_mem_clk    (pll_mem_clk),
        .arst_n         (arst_n),
        .enable_mem_clk (enable_mem_clk),
        .mem_ck         (mem_ck),
        .mem_ck_n       (mem_ck_n)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
)
(
    output logic pll_mem_clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        pll_mem_clk = 1'b0;
        forever
            #(PERIOD_NS / 2) pll_mem_clk = ~pll_mem_clk;
    end

    // release lands on a falling edge, half a period away from the flops
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pll_mem_clk);
        @(negedge pll_mem_clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_addr_cmd_pads.sv */
`default_nettype none

`include "addr_cmd_consts.svh"

module tb_addr_cmd_pads;

    timeunit 1ns;
    timeprecision 1ps;

    import addr_cmd_pkg::*;

    // pair slots: idle levels, one known pair, the random stream, the enable test
    localparam int IDLE            = 0;
    localparam int KNOWN           = 1;
    localparam int FIRST_STREAM    = 2;
    localparam int STREAM_LEN      = 20;
    localparam int OE_PAIR         = FIRST_STREAM + STREAM_LEN;
    localparam int NUM_PAIRS       = OE_PAIR + 1;
    localparam int RELEASE_TIMEOUT = 50;

    logic       pll_mem_clk;
    logic       arst_n;
    ck_en_t     enable_mem_clk;
    addr_pair_t afi_address;
    bank_pair_t afi_bank;
    cs_n_pair_t afi_cs_n;
    cke_pair_t  afi_cke;
    odt_pair_t  afi_odt;
    ctrl_pair_t afi_ras_n;
    ctrl_pair_t afi_cas_n;
    ctrl_pair_t afi_we_n;
    ctrl_pair_t afi_reset_n;
    addr_t      mem_address;
    bank_t      mem_bank;
    cs_n_t      mem_cs_n;
    cke_t       mem_cke;
    odt_t       mem_odt;
    ctrl_t      mem_ras_n;
    ctrl_t      mem_cas_n;
    ctrl_t      mem_we_n;
    ctrl_t      mem_reset_n;
    ck_en_t     mem_ck;
    ck_en_t     mem_ck_n;

    addr_pair_t pair_address [NUM_PAIRS];
    bank_pair_t pair_bank    [NUM_PAIRS];
    cs_n_pair_t pair_cs_n    [NUM_PAIRS];
    cke_pair_t  pair_cke     [NUM_PAIRS];
    odt_pair_t  pair_odt     [NUM_PAIRS];
    ctrl_pair_t pair_ras_n   [NUM_PAIRS];
    ctrl_pair_t pair_cas_n   [NUM_PAIRS];
    ctrl_pair_t pair_we_n    [NUM_PAIRS];
    ctrl_pair_t pair_reset_n [NUM_PAIRS];

    logic [31:0] rng       = 32'hbb38_df8a;
    int          errors    = 0;
    int          checks    = 0;
    bit          timed_out = 1'b0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) u_clock_gen
    (
        .pll_mem_clk (pll_mem_clk),
        .arst_n      (arst_n)
    );

    addr_cmd_pads UUT
    (
        .pll_mem_clk    (pll_mem_clk),
        .arst_n         (arst_n),
        .enable_mem_clk (enable_mem_clk),
        .afi_address    (afi_address),
        .afi_bank       (afi_bank),
        .afi_cs_n       (afi_cs_n),
        .afi_cke        (afi_cke),
        .afi_odt        (afi_odt),
        .afi_ras_n      (afi_ras_n),
        .afi_cas_n      (afi_cas_n),
        .afi_we_n       (afi_we_n),
        .afi_reset_n    (afi_reset_n),
        .mem_address    (mem_address),
        .mem_bank       (mem_bank),
        .mem_cs_n       (mem_cs_n),
        .mem_cke        (mem_cke),
        .mem_odt        (mem_odt),
        .mem_ras_n      (mem_ras_n),
        .mem_cas_n      (mem_cas_n),
        .mem_we_n       (mem_we_n),
        .mem_reset_n    (mem_reset_n),
        .mem_ck         (mem_ck),
        .mem_ck_n       (mem_ck_n)
    );

    // ****************************************
    // stimulus
    // ****************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic build_stimulus();
        int i;
        // idle slot holds every field at its reset level in both halves
        pair_address[IDLE] = '0;
        pair_bank[IDLE]    = '0;
        pair_cs_n[IDLE]    = {2*`CS_W{`CS_N_RST}};
        pair_cke[IDLE]     = {2*`CKE_W{`CKE_RST}};
        pair_odt[IDLE]     = '0;
        pair_ras_n[IDLE]   = {2*`CTRL_W{`CMD_N_RST}};
        pair_cas_n[IDLE]   = {2*`CTRL_W{`CMD_N_RST}};
        pair_we_n[IDLE]    = {2*`CTRL_W{`CMD_N_RST}};
        pair_reset_n[IDLE] = {2*`CTRL_W{`MEM_RESET_RST}};
        // the two halves of the known pair differ in every field
        pair_address[KNOWN] = {addr_t'(15'h5a3c), addr_t'(15'h21c7)};
        pair_bank[KNOWN]    = {bank_t'(3'h6), bank_t'(3'h1)};
        pair_cs_n[KNOWN]    = {cs_n_t'(0), ~cs_n_t'(0)};
        pair_cke[KNOWN]     = {~cke_t'(0), cke_t'(0)};
        pair_odt[KNOWN]     = {odt_t'(0), ~odt_t'(0)};
        pair_ras_n[KNOWN]   = {~ctrl_t'(0), ctrl_t'(0)};
        pair_cas_n[KNOWN]   = {ctrl_t'(0), ~ctrl_t'(0)};
        pair_we_n[KNOWN]    = {~ctrl_t'(0), ctrl_t'(0)};
        pair_reset_n[KNOWN] = {ctrl_t'(0), ~ctrl_t'(0)};
        for (i = FIRST_STREAM; i < NUM_PAIRS; i++)
        begin
            rng = xorshift32(rng);
            pair_address[i] = addr_pair_t'(rng);
            rng = xorshift32(rng);
            pair_bank[i]    = bank_pair_t'(rng);
            pair_cs_n[i]    = cs_n_pair_t'(rng >> 8);
            pair_cke[i]     = cke_pair_t'(rng >> 12);
            pair_odt[i]     = odt_pair_t'(rng >> 14);
            pair_ras_n[i]   = ctrl_pair_t'(rng >> 16);
            pair_cas_n[i]   = ctrl_pair_t'(rng >> 18);
            pair_we_n[i]    = ctrl_pair_t'(rng >> 20);
            pair_reset_n[i] = ctrl_pair_t'(rng >> 22);
        end
    endtask

    task automatic drive_pair(input int idx);
        afi_address = pair_address[idx];
        afi_bank    = pair_bank[idx];
        afi_cs_n    = pair_cs_n[idx];
        afi_cke     = pair_cke[idx];
        afi_odt     = pair_odt[idx];
        afi_ras_n   = pair_ras_n[idx];
        afi_cas_n   = pair_cas_n[idx];
        afi_we_n    = pair_we_n[idx];
        afi_reset_n = pair_reset_n[idx];
    endtask

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_ck(input string name, input ck_en_t got, input ck_en_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // one half of a pair on every pin, the gated ones floating unless driven
    task automatic check_words(input int idx, input bit hi_half, input bit driven);
        int    sel;
        addr_t exp_address;
        bank_t exp_bank;
        cs_n_t exp_cs_n;
        odt_t  exp_odt;
        ctrl_t exp_ras_n;
        ctrl_t exp_cas_n;
        ctrl_t exp_we_n;
        sel         = hi_half ? 1 : 0;
        exp_address = pair_address[idx][sel*`ADDR_W +: `ADDR_W];
        exp_bank    = pair_bank[idx][sel*`BANK_W +: `BANK_W];
        exp_cs_n    = pair_cs_n[idx][sel*`CS_W +: `CS_W];
        exp_odt     = pair_odt[idx][sel*`ODT_W +: `ODT_W];
        exp_ras_n   = pair_ras_n[idx][sel*`CTRL_W +: `CTRL_W];
        exp_cas_n   = pair_cas_n[idx][sel*`CTRL_W +: `CTRL_W];
        exp_we_n    = pair_we_n[idx][sel*`CTRL_W +: `CTRL_W];
        if (!driven)
        begin
            exp_address = 'z;
            exp_bank    = 'z;
            exp_cs_n    = 'z;
            exp_odt     = 'z;
            exp_ras_n   = 'z;
            exp_cas_n   = 'z;
            exp_we_n    = 'z;
        end
        check_addr("mem_address", mem_address, exp_address);
        check_bank("mem_bank", mem_bank, exp_bank);
        check_ctrl("mem_cs_n", mem_cs_n, exp_cs_n);
        check_ctrl("mem_odt", mem_odt, exp_odt);
        check_ctrl("mem_ras_n", mem_ras_n, exp_ras_n);
        check_ctrl("mem_cas_n", mem_cas_n, exp_cas_n);
        check_ctrl("mem_we_n", mem_we_n, exp_we_n);
        check_ctrl("mem_cke", mem_cke, pair_cke[idx][sel*`CKE_W +: `CKE_W]);
        check_ctrl("mem_reset_n", mem_reset_n, pair_reset_n[idx][sel*`CTRL_W +: `CTRL_W]);
    endtask

    task automatic check_clock_pair(input bit running);
        ck_en_t exp_ck;
        exp_ck = running ? {`CK_W{pll_mem_clk}} : '0;
        check_ck("mem_ck", mem_ck, exp_ck);
        check_ck("mem_ck_n", mem_ck_n, ~exp_ck);
    endtask

    // returns on the first rising edge that sees arst_n high
    task automatic wait_release();
        int n;
        for (n = 0; n < RELEASE_TIMEOUT; n++)
        begin
            @(posedge pll_mem_clk);
            if (arst_n === 1'b1)
                return;
        end
        $display("timeout: arst_n was still low after %0d clock cycles", RELEASE_TIMEOUT);
        errors++;
        timed_out = 1'b1;
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic test_reset_levels();
        // the enable is held high in reset so only the reset keeps the pins
        // floating and the clock pair parked
        enable_mem_clk = '1;
        repeat (2)
        begin
            @(posedge pll_mem_clk);
            #5;
            check_clock_pair(1'b0);
            @(negedge pll_mem_clk);
            check_words(IDLE, 1'b0, 1'b0);
        end
        enable_mem_clk = '0;
        wait_release();
        if (timed_out)
            return;
        // edges 1 and 2 after the release come before any capture
        #5;
        check_clock_pair(1'b0);
        @(negedge pll_mem_clk);
        check_words(IDLE, 1'b0, 1'b0);
        @(posedge pll_mem_clk);
        #5;
        check_clock_pair(1'b0);
        @(negedge pll_mem_clk);
        check_words(IDLE, 1'b0, 1'b0);
    endtask

    task automatic test_serial_order();
        enable_mem_clk = '1;
        drive_pair(KNOWN);
        // edge 3 turns the output enable on while the words still idle
        @(negedge pll_mem_clk);
        check_words(IDLE, 1'b0, 1'b1);
        @(negedge pll_mem_clk);
        check_words(KNOWN, 1'b0, 1'b1);
        @(negedge pll_mem_clk);
        check_words(KNOWN, 1'b1, 1'b1);
    endtask

    task automatic test_stream();
        int n;
        // edge 6 captures the known pair a second time
        @(negedge pll_mem_clk);
        check_words(KNOWN, 1'b0, 1'b1);
        for (n = 0; n <= 2*STREAM_LEN; n++)
        begin
            if (n % 2 == 0 && n < 2*STREAM_LEN)
                drive_pair(FIRST_STREAM + n/2);
            @(negedge pll_mem_clk);
            if (n == 0)
                check_words(KNOWN, 1'b1, 1'b1);
            else
                check_words(FIRST_STREAM + (n-1)/2, n % 2 == 0, 1'b1);
        end
    endtask

    task automatic test_output_enable();
        // next edge is a capture edge and takes the last stream pair again
        @(negedge pll_mem_clk);
        check_words(OE_PAIR - 1, 1'b0, 1'b1);
        drive_pair(OE_PAIR);
        enable_mem_clk = '0;
        @(negedge pll_mem_clk);
        check_words(OE_PAIR - 1, 1'b1, 1'b0);
        @(negedge pll_mem_clk);
        check_words(OE_PAIR, 1'b0, 1'b0);
        @(negedge pll_mem_clk);
        check_words(OE_PAIR, 1'b1, 1'b0);
        enable_mem_clk = '1;
        @(negedge pll_mem_clk);
        check_words(OE_PAIR, 1'b0, 1'b1);
        @(negedge pll_mem_clk);
        check_words(OE_PAIR, 1'b1, 1'b1);
    endtask

    task automatic test_mem_ck_gate();
        enable_mem_clk = '0;
        // the falling-edge enable flop may take the new value one cycle late
        @(negedge pll_mem_clk);
        repeat (4)
        begin
            @(posedge pll_mem_clk);
            #5;
            check_clock_pair(1'b0);
            @(negedge pll_mem_clk);
            #5;
            check_clock_pair(1'b0);
        end
        @(negedge pll_mem_clk);
        enable_mem_clk = '1;
        @(negedge pll_mem_clk);
        repeat (4)
        begin
            @(posedge pll_mem_clk);
            #5;
            check_clock_pair(1'b1);
            @(negedge pll_mem_clk);
            #5;
            check_clock_pair(1'b1);
        end
    endtask

    initial
    begin
        build_stimulus();
        enable_mem_clk = '0;
        drive_pair(IDLE);
        test_reset_levels();
        if (!timed_out)
        begin
            test_serial_order();
            test_stream();
            test_output_enable();
            test_mem_ck_gate();
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/addr_cmd_pkg.sv
verilog/hr_phase_gen.sv
verilog/hr_to_fr_serializer.sv
verilog/cmd_out_stage.sv
verilog/mem_ck_gen.sv
verilog/addr_cmd_pads.sv
verif/tb_clock_gen.sv
verif/tb_addr_cmd_pads.sv

/* Bender.yml */
package:
  name: addr_cmd_pads

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/addr_cmd_pkg.sv
      - verilog/hr_phase_gen.sv
      - verilog/hr_to_fr_serializer.sv
      - verilog/cmd_out_stage.sv
      - verilog/mem_ck_gen.sv
      - verilog/addr_cmd_pads.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_addr_cmd_pads.sv
